/* source/cache_pkg.sv */
package cache_pkg;

	// **************************************************
	// geometry
	// **************************************************
	localparam int addr_w          = 16; // processor address width, byte addressed
	localparam int data_w          = 16; // one processor word
	localparam int tag_w           = 8;  // address bits [15:8]
	localparam int index_w         = 4;  // address bits [7:4], picks one of the lines
	localparam int offset_w        = 3;  // address bits [3:1], word inside a block
	localparam int num_lines       = 16; // direct mapped, one block per line
	localparam int words_per_block = 8;  // 16 byte block

	// **************************************************
	// address and storage layouts
	// **************************************************

	// the byte address split into its cache fields, msb first
	typedef struct packed {
		logic [tag_w-1:0]    tag;      // compared against the stored tag
		logic [index_w-1:0]  index;    // selects the line
		logic [offset_w-1:0] offset;   // selects the word in the block
		logic                byte_sel; // ignored, only word loads exist
	} cache_addr_t;

	// one entry of the tag store
	typedef struct packed {
		logic             valid; // line holds a complete block
		logic [tag_w-1:0] tag;   // tag of the block held in the line
	} tag_entry_t;

	// **************************************************
	// port payloads
	// **************************************************
	typedef struct packed {
		cache_addr_t addr; // load address from the processor
	} cache_req_t;

	typedef struct packed {
		logic [data_w-1:0] data; // loaded word
		logic              hit;  // set when the first lookup found the block
	} cache_rsp_t;

	typedef struct packed {
		logic              read; // memory takes a read on every cycle this is high
		logic [addr_w-1:0] addr; // word aligned read address
	} mem_req_t;

	typedef struct packed {
		logic              valid; // one returned word, in request order
		logic [data_w-1:0] data;
	} mem_rsp_t;

	// **************************************************
	// state encodings
	// **************************************************
	typedef enum logic [1:0] {lk_idle, lk_compare, lk_fill, lk_respond} lookup_state_t;

	typedef enum logic [1:0] {fill_idle, fill_active, fill_done} fill_state_t;

endpackage

/* source/cache_tag_store.sv */
`timescale 1ns/1ps

module cache_tag_store (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   rd_en,           // lookup read strobe
	input  cache_pkg::cache_addr_t rd_addr,         // only the index field is used here
	output cache_pkg::tag_entry_t  rd_entry,        // entry of the read index, one cycle later
	input  logic                   write_tag_array, // fill FSM installs a tag
	input  cache_pkg::cache_addr_t base_addr        // block address of the current fill
);

	// one valid bit per line, set once its block is complete
	logic [cache_pkg::num_lines-1:0] valid_bits;

	// tag of the block held in each line
	logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::num_lines];

	// **************************************************
	// fill write port
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0; // every line starts out empty
		end else if (write_tag_array) begin
			valid_bits[base_addr.index] <= 1'b1; // block is now complete in the data store
		end
	end

	always_ff @(posedge clk) begin
		if (write_tag_array) begin
			tag_mem[base_addr.index] <= base_addr.tag; // tag goes in with the valid bit
		end
	end

	// **************************************************
	// lookup read port
	// **************************************************

	// registered read so the tag arrives alongside the data store word
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_entry.valid <= valid_bits[rd_addr.index];
			rd_entry.tag   <= tag_mem[rd_addr.index];
		end
	end

	// the lookup only reads while no fill is writing this line, since a read of a line under
	// fill would see a stale valid bit and report a bogus hit or miss
	assert property (@(posedge clk) disable iff (rst)
		!(rd_en && write_tag_array && (rd_addr.index == base_addr.index)))
	else $error("tag store read and write collide on index %0d", rd_addr.index);

endmodule

/* source/cache_data_store.sv */
`timescale 1ns/1ps

module cache_data_store (
	input  logic                          clk,
	input  logic                          rd_en,                    // lookup read strobe
	input  cache_pkg::cache_addr_t        rd_addr,                  // index and word offset
	output logic [cache_pkg::data_w-1:0]  rd_data,                  // word, one cycle after rd_en
	input  logic                          write_data_array,         // one returned memory word
	input  cache_pkg::cache_addr_t        base_addr,                // block being filled
	input  logic [cache_pkg::offset_w-1:0] cache_write_block_offset, // word slot for wr_data
	input  logic [cache_pkg::data_w-1:0]  wr_data                   // straight from the memory bus
);

	// flat word address is {line index, word offset}
	localparam int word_addr_w = cache_pkg::index_w + cache_pkg::offset_w;

	// **************************************************
	// storage
	// **************************************************

	// 16 lines of 8 words, contents are only trusted behind a valid tag
	logic [cache_pkg::data_w-1:0] data_mem [cache_pkg::num_lines * cache_pkg::words_per_block];

	logic [word_addr_w-1:0] rd_word; // word picked by the lookup
	logic [word_addr_w-1:0] wr_word; // word picked by the fill

	assign rd_word = {rd_addr.index, rd_addr.offset};
	assign wr_word = {base_addr.index, cache_write_block_offset}; // fill counts words in order

	// **************************************************
	// write port
	// **************************************************

	// the fill FSM raises the strobe once per returned word
	always_ff @(posedge clk) begin
		if (write_data_array) begin
			data_mem[wr_word] <= wr_data;
		end
	end

	// **************************************************
	// read port
	// **************************************************

	// registered read that lines up with the tag store output
	// the lookup never reads a line while it is being filled, so there is no
	// read during write ordering to worry about
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= data_mem[rd_word]; // held until the next read strobe
		end
	end

endmodule

/* source/cache_fill_fsm.sv */
`timescale 1ns/1ps

module cache_fill_fsm (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           miss_detected,            // one cycle pulse from lookup
	input  cache_pkg::cache_addr_t         miss_addr,                // address that missed
	output cache_pkg::mem_req_t            mem_req,                  // word reads to memory
	input  cache_pkg::mem_rsp_t            mem_rsp,                  // words back, in order
	output logic                           write_data_array,         // data store write strobe
	output logic [cache_pkg::offset_w-1:0] cache_write_block_offset, // word slot being written
	output logic                           write_tag_array,          // closes the fill
	output cache_pkg::cache_addr_t         base_addr,                // block aligned miss address
	output logic                           fsm_busy                  // holds the lookup off
);

	// last word offset of a block, shared by both counters
	localparam logic [cache_pkg::offset_w-1:0] last_word =
		cache_pkg::offset_w'(cache_pkg::words_per_block - 1);

	cache_pkg::fill_state_t state; // active while reads go out, done while words still return

	logic [cache_pkg::offset_w-1:0] rd_cnt; // word offset of the next memory read
	logic [cache_pkg::offset_w-1:0] wr_cnt; // word offset of the next returning word
	logic                           finish_write; // eighth word arrives this cycle
	cache_pkg::cache_addr_t         rd_word_addr; // base plus read offset

	// **************************************************
	// state and counters
	// **************************************************

	assign finish_write = write_data_array && (wr_cnt == last_word);

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= cache_pkg::fill_idle;
			rd_cnt <= '0;
			wr_cnt <= '0;
		end else begin
			case (state)
				cache_pkg::fill_idle: begin
					if (miss_detected) begin
						state  <= cache_pkg::fill_active; // reads start next cycle
						rd_cnt <= '0;
						wr_cnt <= '0;
					end
				end
				cache_pkg::fill_active: begin
					rd_cnt <= rd_cnt + 1'b1; // one read per cycle, memory never stalls
					if (rd_cnt == last_word) begin
						state <= cache_pkg::fill_done; // all eight reads are out
					end
				end
				default: ; // fill_done just waits for the returns
			endcase

			// returns are counted in both busy states, memory latency is unknown
			if (write_data_array) begin
				wr_cnt <= wr_cnt + 1'b1; // wraps back to zero on the eighth word
			end
			if (finish_write) begin
				state <= cache_pkg::fill_idle; // busy drops the cycle after the tag write
			end
		end
	end

	// latch the block base once per miss, word and byte bits cleared
	always_ff @(posedge clk) begin
		if ((state == cache_pkg::fill_idle) && miss_detected) begin
			base_addr.tag      <= miss_addr.tag;
			base_addr.index    <= miss_addr.index;
			base_addr.offset   <= '0;
			base_addr.byte_sel <= 1'b0;
		end
	end

	// **************************************************
	// outputs
	// **************************************************

	always_comb begin
		rd_word_addr        = base_addr;
		rd_word_addr.offset = rd_cnt; // base, base+2, ... base+14
	end

	assign mem_req.read = (state == cache_pkg::fill_active); // exactly eight cycles
	assign mem_req.addr = rd_word_addr;

	assign fsm_busy                 = (state != cache_pkg::fill_idle);
	assign write_data_array         = fsm_busy && mem_rsp.valid; // wr_data is the bus itself
	assign cache_write_block_offset = wr_cnt;
	assign write_tag_array          = finish_write; // same cycle as the last data write

	// memory only answers reads this FSM issued
	assert property (@(posedge clk) disable iff (rst)
		mem_rsp.valid |-> (state != cache_pkg::fill_idle))
	else $error("memory returned a word with no fill in progress");

	// the lookup holds one request and waits out the fill before a new miss
	assert property (@(posedge clk) disable iff (rst) miss_detected |-> !fsm_busy)
	else $error("miss reported while a fill is still running");

endmodule

/* source/cache_lookup.sv */
`timescale 1ns/1ps

module cache_lookup (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  cache_pkg::cache_req_t         req,
	output logic                          req_ready,     // only open in lk_idle
	output logic                          rsp_valid,
	output cache_pkg::cache_rsp_t         rsp,
	input  logic                          rsp_ready,
	output logic                          rd_en,         // read strobe to both stores
	output cache_pkg::cache_addr_t        rd_addr,
	input  cache_pkg::tag_entry_t         rd_entry,      // tag store result
	input  logic [cache_pkg::data_w-1:0]  rd_data,       // data store result
	output logic                          miss_detected, // starts a fill
	output cache_pkg::cache_addr_t        miss_addr,
	input  logic                          fsm_busy       // fill still running
);

	cache_pkg::lookup_state_t state;

	cache_pkg::cache_req_t req_q;     // request held until its response is taken
	logic                  rd_pend;   // store read issued, results visible this cycle
	logic                  first_try; // cleared once the request has missed
	logic                  tag_hit;   // valid entry with a matching tag

	// **************************************************
	// store access and compare
	// **************************************************

	// the read goes out the cycle after acceptance, or as soon as the fill lets go
	assign rd_en   = ((state == cache_pkg::lk_compare) && !rd_pend) ||
	                 ((state == cache_pkg::lk_fill) && !fsm_busy);
	assign rd_addr = req_q.addr; // both stores see the same address

	assign tag_hit = rd_entry.valid && (rd_entry.tag == req_q.addr.tag);

	// a single cycle pulse because the state leaves lk_compare on the same edge
	assign miss_detected = (state == cache_pkg::lk_compare) && rd_pend && !tag_hit;
	assign miss_addr     = req_q.addr;

	assign req_ready = (state == cache_pkg::lk_idle);
	assign rsp_valid = (state == cache_pkg::lk_respond);

	// **************************************************
	// request and response sequencing
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= cache_pkg::lk_idle;
			rd_pend   <= 1'b0;
			first_try <= 1'b0;
		end else begin
			if (rd_en) rd_pend <= 1'b1; // results come back on the next cycle
			case (state)
				cache_pkg::lk_idle: begin
					if (req_valid) begin
						state     <= cache_pkg::lk_compare;
						rd_pend   <= 1'b0;
						first_try <= 1'b1;
					end
				end
				cache_pkg::lk_compare: begin
					if (rd_pend) begin
						state <= tag_hit ? cache_pkg::lk_respond : cache_pkg::lk_fill;
						if (!tag_hit) first_try <= 1'b0; // the replay reports a miss
					end
				end
				cache_pkg::lk_fill: begin
					// fsm_busy is already high on the first cycle here
					if (!fsm_busy) state <= cache_pkg::lk_compare; // replay, read issued now
				end
				default: begin
					if (rsp_ready) state <= cache_pkg::lk_idle; // response taken
				end
			endcase
		end
	end

	// payload registers, no reset needed
	always_ff @(posedge clk) begin
		if (req_ready && req_valid) req_q <= req;
		if ((state == cache_pkg::lk_compare) && rd_pend && tag_hit) begin
			rsp.data <= rd_data;
			rsp.hit  <= first_try; // hit only if no fill was needed
		end
	end

	// a stalled response must not change under the processor
	assert property (@(posedge clk) disable iff (rst)
		(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
	else $error("response changed while stalled");

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_valid,
	input  cache_pkg::cache_req_t req,
	output logic                  req_ready,
	output logic                  rsp_valid,
	output cache_pkg::cache_rsp_t rsp,
	input  logic                  rsp_ready,
	output cache_pkg::mem_req_t   mem_req,  // block reads during a fill
	input  cache_pkg::mem_rsp_t   mem_rsp   // returned words
);

	// **************************************************
	// lookup to store and fill wiring
	// **************************************************
	logic                           rd_en;
	cache_pkg::cache_addr_t         rd_addr;
	cache_pkg::tag_entry_t          rd_entry;
	logic [cache_pkg::data_w-1:0]   rd_data;
	logic                           miss_detected;
	cache_pkg::cache_addr_t         miss_addr;
	logic                           fsm_busy;
	logic                           write_data_array;
	logic                           write_tag_array;
	logic [cache_pkg::offset_w-1:0] cache_write_block_offset;
	cache_pkg::cache_addr_t         base_addr;

	cache_lookup cache_lookup_inst (
		.clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp, .rsp_ready,
		.rd_en, .rd_addr, .rd_entry, .rd_data, .miss_detected, .miss_addr, .fsm_busy
	);

	// both stores read side by side on the same strobe
	cache_tag_store cache_tag_store_inst (
		.clk, .rst, .rd_en, .rd_addr, .rd_entry, .write_tag_array, .base_addr
	);

	cache_data_store cache_data_store_inst (
		.clk, .rd_en, .rd_addr, .rd_data, .write_data_array, .base_addr,
		.cache_write_block_offset,
		.wr_data (mem_rsp.data) // fill words go straight in from the bus
	);

	cache_fill_fsm cache_fill_fsm_inst (
		.clk, .rst, .miss_detected, .miss_addr, .mem_req, .mem_rsp, .write_data_array,
		.cache_write_block_offset, .write_tag_array, .base_addr, .fsm_busy
	);

endmodule

/* verification/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

	// **************************************************
	// constants, DUT ports and scoreboard state
	// **************************************************
	localparam logic [15:0] mem_key    = 16'hc3a5; // memory word is its address xor this
	localparam int random_requests     = 200;
	localparam int cycles_per_request  = 40;       // loose bound on a stalled miss
	localparam int clk_period_ns       = 40;
	localparam int watchdog_ns         = random_requests * cycles_per_request * clk_period_ns;

	logic                  clk;
	logic                  rst;
	logic                  req_valid;
	cache_pkg::cache_req_t req;
	logic                  req_ready;
	logic                  rsp_valid;
	cache_pkg::cache_rsp_t rsp;
	logic                  rsp_ready;
	cache_pkg::mem_req_t   mem_req;
	cache_pkg::mem_rsp_t   mem_rsp;

	int                              cycle = 0;               // posedges seen so far
	string                           test_name = "reset";
	logic                            stall_en = 1'b0;         // random rsp_ready when set
	logic [31:0]                     req_lfsr = 32'h3b006c62;   // addresses and gaps
	logic [31:0]                     stall_lfsr = 32'h3b006c62; // rsp_ready stalls
	logic [cache_pkg::num_lines-1:0] ref_valid = '0;
	logic [cache_pkg::tag_w-1:0]     ref_tag [cache_pkg::num_lines];
	cache_pkg::cache_rsp_t           exp_rsp_q [$]; // one entry per accepted request
	int                              exp_acc_q [$]; // acceptance edge of that request
	cache_pkg::mem_req_t             exp_mem_q [$]; // fill reads still to come
	int                              mem_due_q [$]; // cycle a pending word is driven
	logic [15:0]                     mem_data_q [$];
	int                              requests_sent = 0;
	int                              responses_done = 0;

	cache_top cache_top_inst (
		.clk, .rst, .req_valid, .req, .req_ready, .rsp_valid, .rsp, .rsp_ready,
		.mem_req, .mem_rsp
	);

	initial clk = 1'b0;
	always #(clk_period_ns / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1; // read only on falling edges

	// **************************************************
	// helpers
	// **************************************************
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_rsp(input string name, input cache_pkg::cache_rsp_t exp,
			input cache_pkg::cache_rsp_t act);
		if (act !== exp)
			stop_with_failure($sformatf("[FAIL] %s: expected data %h hit %b, actual data %h hit %b",
				name, exp.data, exp.hit, act.data, act.hit));
	endtask

	task automatic check_mem_req(input string name, input cache_pkg::mem_req_t exp,
			input cache_pkg::mem_req_t act);
		if (act !== exp)
			stop_with_failure($sformatf("[FAIL] %s: expected read %b addr %h, actual read %b addr %h",
				name, exp.read, exp.addr, act.read, act.addr));
	endtask

	// taps 32, 22, 2, 1 shifted in at the bottom
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_req_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			req_lfsr = lfsr_step(req_lfsr); // one step per bit taken
			bits     = {bits[30:0], req_lfsr[0]};
		end
		return bits;
	endfunction

	// ready three cycles in four
	function automatic logic take_stall_bit();
		logic [1:0] bits;
		stall_lfsr = lfsr_step(stall_lfsr);
		bits[0]    = stall_lfsr[0];
		stall_lfsr = lfsr_step(stall_lfsr);
		bits[1]    = stall_lfsr[0];
		return bits != 2'b00;
	endfunction

	// direct mapped model, a miss always installs the block
	function automatic cache_pkg::cache_rsp_t ref_lookup(input cache_pkg::cache_addr_t a);
		cache_pkg::cache_rsp_t r;
		r.hit              = ref_valid[a.index] && (ref_tag[a.index] == a.tag);
		r.data             = {a.tag, a.index, a.offset, 1'b0} ^ mem_key; // byte bit ignored
		ref_valid[a.index] = 1'b1;
		ref_tag[a.index]   = a.tag;
		return r;
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_request(input cache_pkg::cache_addr_t a);
		cache_pkg::cache_rsp_t exp;
		cache_pkg::mem_req_t   rd;
		req_valid = 1'b1;
		req.addr  = a;
		while (req_ready !== 1'b1) @(negedge clk); // the request waits for the port to open
		if (exp_rsp_q.size() != 0)
			stop_with_failure("a request was accepted while a response was still owed");
		exp = ref_lookup(a);
		exp_rsp_q.push_back(exp);
		exp_acc_q.push_back(cycle + 1); // taken on the coming rising edge
		if (!exp.hit) begin
			for (int k = 0; k < cache_pkg::words_per_block; k++) begin
				rd.read = 1'b1;
				rd.addr = {a.tag, a.index, 3'(k), 1'b0}; // base, base+2 up to base+14
				exp_mem_q.push_back(rd);
			end
		end
		requests_sent++;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_for_responses();
		while (responses_done != requests_sent) @(negedge clk);
	endtask

	// **************************************************
	// response side, drives rsp_ready and compares
	// **************************************************
	initial begin : response_side
		logic holding; // the waiting response was already seen on an earlier cycle
		holding   = 1'b0;
		rsp_ready = 1'b0;
		forever begin
			@(negedge clk);
			rsp_ready = stall_en ? take_stall_bit() : 1'b1;
			if (!rst && rsp_valid === 1'b1) begin
				if (req_ready !== 1'b0)
					stop_with_failure("the request port was open while a response waited");
				if (exp_rsp_q.size() == 0)
					stop_with_failure("a response appeared with no request outstanding");
				if (!holding) begin
					// a hit answers two edges after acceptance
					if (exp_rsp_q[0].hit && cycle != exp_acc_q[0] + 2)
						stop_with_failure($sformatf("[FAIL] %s hit latency: expected 2, actual %0d",
							test_name, cycle - exp_acc_q[0]));
					holding = 1'b1;
				end
				check_rsp(test_name, exp_rsp_q[0], rsp); // every stalled cycle shows the same word
				if (rsp_ready) begin
					if (exp_mem_q.size() != 0)
						stop_with_failure("a response came back before all eight fill reads");
					void'(exp_rsp_q.pop_front());
					void'(exp_acc_q.pop_front());
					holding = 1'b0;
					responses_done++;
				end
			end else if (!rst && holding) begin
				stop_with_failure("rsp_valid dropped before the response was accepted");
			end
		end
	end

	// **************************************************
	// memory model, fixed three cycle return
	// **************************************************
	initial begin : memory_model
		int last_read; // cycle of the previous fill read
		last_read = 0;
		mem_rsp   = '0;
		forever begin
			@(negedge clk);
			if (mem_req.read === 1'b1) begin
				if (exp_mem_q.size() == 0)
					stop_with_failure("memory saw a read with no fill expected");
				if (exp_mem_q.size() != cache_pkg::words_per_block && cycle != last_read + 1)
					stop_with_failure("fill reads were not issued on consecutive cycles");
				check_mem_req({test_name, " fill read"}, exp_mem_q[0], mem_req);
				void'(exp_mem_q.pop_front());
				last_read = cycle;
				mem_due_q.push_back(cycle + 3);
				mem_data_q.push_back(mem_req.addr ^ mem_key);
			end
			if (mem_due_q.size() != 0 && mem_due_q[0] <= cycle) begin
				mem_rsp.valid = 1'b1; // words leave in request order
				mem_rsp.data  = mem_data_q[0];
				void'(mem_due_q.pop_front());
				void'(mem_data_q.pop_front());
			end else begin
				mem_rsp = '0;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_ns);
		stop_with_failure("the run timed out before all requests were answered");
	end

	// **************************************************
	// stimulus
	// **************************************************
	initial begin : stimulus
		cache_pkg::cache_addr_t a;
		cache_pkg::cache_addr_t b;
		logic [3:0]             idx_choice [4];
		int                     gap;
		idx_choice = '{4'h1, 4'h3, 4'h6, 4'hc}; // few lines so conflicts are common
		rst        = 1'b1;
		req_valid  = 1'b0;
		req        = '0;
		repeat (16) @(negedge clk);
		rst = 1'b0;

		test_name = "idle after reset";
		repeat (4) begin
			@(negedge clk);
			if (req_ready !== 1'b1 || rsp_valid !== 1'b0 || mem_req.read !== 1'b0)
				stop_with_failure("the ports were not idle after reset");
		end

		test_name = "first access"; // cold line, eight reads and hit 0
		a = {8'h12, 4'h3, 3'd5, 1'b0};
		send_request(a);
		wait_for_responses();

		test_name = "repeat hit"; // same block, no memory traffic
		a.offset = 3'd2;
		send_request(a);
		a.offset = 3'd7;
		send_request(a);
		wait_for_responses();

		test_name = "conflict"; // same index, tags evict each other
		a = {8'h12, 4'h6, 3'd1, 1'b0};
		b = {8'h5a, 4'h6, 3'd7, 1'b0};
		repeat (3) begin
			send_request(a);
			send_request(b);
		end
		wait_for_responses();

		test_name = "stalled responses"; // back to back requests against a slow consumer
		stall_en  = 1'b1;
		for (int i = 0; i < 12; i++) begin
			send_request((i % 4 < 2) ? a : b);
		end
		wait_for_responses();

		test_name = "random";
		for (int i = 0; i < random_requests; i++) begin
			a.tag      = take_req_bits(1) != 0 ? 8'h5a : 8'h12;
			a.index    = idx_choice[2'(take_req_bits(2))];
			a.offset   = 3'(take_req_bits(3));
			a.byte_sel = take_req_bits(1) != 0;
			gap        = int'(take_req_bits(2));
			send_request(a);
			repeat (gap) @(negedge clk);
		end
		wait_for_responses();

		$display("All checks passed");
		$finish;
	end

endmodule

/* files.f */
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_fill_fsm.sv
source/cache_lookup.sv
source/cache_top.sv
verification/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
